// File: list.f
logic/mcu_pkg.sv
logic/emul_table.sv
logic/store_ctrl.sv
logic/load_ctrl.sv
logic/mcu_top.sv
sim/mcu_tb.sv

// File: logic/emul_table.sv
////////////////////////////////////////
// EMUL lookup table with a flag for
// illegal SEW/LMUL/width combinations
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module emul_table (
  input  mcu_pkg::mcu_req_t           req_i,
  output logic [mcu_pkg::CODE_W-1:0]  emul_o,
  output logic                        emul_valid_o
);

  // Each entry holds {valid, emul}, index is {width, lmul, sew}
  function automatic logic [127:0][mcu_pkg::CODE_W:0] build_rom();
    logic [127:0][mcu_pkg::CODE_W:0] rom;
    logic [mcu_pkg::CODE_W-1:0]      lmul;
    logic [1:0]                      width;
    logic [1:0]                      sew;
    logic signed [4:0]               sum;
    logic                            ok;
    for (int i = 0; i < 128; i++) begin
      width = i[6:5];
      lmul  = i[4:2];
      sew   = i[1:0];
      // log2 arithmetic, LMUL code read as signed
      sum = $signed(lmul) + $signed({3'b000, width}) - $signed({3'b000, sew});
      ok  = (lmul != mcu_pkg::LMUL_RESERVED) && (width != 2'd3) && (sew != 2'd3) &&
            (sum >= -3) && (sum <= 3);
      rom[i] = {ok, sum[mcu_pkg::CODE_W-1:0]};
    end
    return rom;
  endfunction

  logic [127:0][mcu_pkg::CODE_W:0] emul_rom;
  logic [6:0]                      rom_idx;
  logic [mcu_pkg::CODE_W:0]        rom_word;

  assign emul_rom = build_rom();
  assign rom_idx  = {req_i.data_width[1:0], req_i.lmul, req_i.sew[1:0]};
  assign rom_word = emul_rom[rom_idx];

  assign emul_o = rom_word[mcu_pkg::CODE_W-1:0];

  // Codes above 3 fall outside the indexed range
  assign emul_valid_o = rom_word[mcu_pkg::CODE_W] && !req_i.sew[2] && !req_i.data_width[2];

endmodule

`default_nettype wire

// File: logic/load_ctrl.sv
////////////////////////////////////////
// Load controller: AXI read data into the
// load buffer, buffer out to the lanes
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module load_ctrl (
  input  logic                        clk,
  input  logic                        rstn,
  // Scheduler
  input  mcu_pkg::mcu_req_t           req_i,
  input  logic                        ld_vld_i,
  output logic                        ld_rdy_o,
  // EMUL lookup
  input  logic [mcu_pkg::CODE_W-1:0]  emul_i,
  input  logic                        emul_valid_i,
  // Buffer array
  output mcu_pkg::mem_cfg_t           load_cfg_o,
  output logic                        cfg_update_o,
  output logic                        cntr_rst_o,
  output logic                        baseaddr_set_o,
  output logic                        baseaddr_update_o,
  output logic                        ldbuff_wen_o,
  output logic                        ldbuff_ren_o,
  output logic                        ldbuff_read_stall_o,
  output logic                        ldbuff_read_flush_o,
  input  logic                        ldbuff_write_done_i,
  input  logic                        ldbuff_read_done_i,
  // Vector lanes
  input  logic                        vlane_load_rdy_i,
  output logic                        vlane_load_dvalid_o,
  output logic                        vlane_load_last_o,
  // AXI read channel
  output logic                        ctrl_rstart_o,
  input  logic                        ctrl_rdone_i,
  input  logic                        rd_tvalid_i,
  output logic                        rd_tready_o,
  input  logic                        rd_tlast_i
);

  mcu_pkg::load_rd_fsm_e             rd_q, rd_d;
  mcu_pkg::load_wr_fsm_e             wr_q, wr_d;
  logic                              cfg_save;
  logic                              start_wr;
  logic                              buffered;
  logic                              rstart_lvl;
  logic                              rstart_q;
  logic                              rvalid;
  logic [mcu_pkg::DLINE_DEPTH-1:0]   dline;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_q     <= mcu_pkg::LR_IDLE;
      wr_q     <= mcu_pkg::LW_IDLE;
      rstart_q <= 1'b0;
    end else begin
      rd_q     <= rd_d;
      wr_q     <= wr_d;
      rstart_q <= rstart_lvl;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      load_cfg_o <= '0;
    end else if (cfg_save) begin
      load_cfg_o.mode <= req_i.strided ? mcu_pkg::MODE_STRIDED : mcu_pkg::MODE_UNIT;
      load_cfg_o.eew  <= req_i.data_width;
      load_cfg_o.emul <= emul_i;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dline <= '0;
    end else if (!ldbuff_read_stall_o) begin
      dline <= {dline[mcu_pkg::DLINE_DEPTH-2:0], rvalid};
    end
  end

  assign ctrl_rstart_o       = rstart_lvl && !rstart_q;
  assign vlane_load_dvalid_o = dline[1];
  // Beat at the output tap with nothing queued behind it
  assign vlane_load_last_o   = (dline[1:0] == 2'b10);
  assign ldbuff_read_flush_o = (rd_q == mcu_pkg::LR_READ) && (dline == '0);

  ////////////////////////////////////////
  // Load buffer to lanes
  ////////////////////////////////////////
  always_comb begin
    rd_d                = rd_q;
    ld_rdy_o            = 1'b0;
    cfg_save            = 1'b0;
    baseaddr_set_o      = 1'b0;
    cfg_update_o        = 1'b0;
    cntr_rst_o          = 1'b0;
    start_wr            = 1'b0;
    rvalid              = 1'b0;
    ldbuff_ren_o        = 1'b0;
    ldbuff_read_stall_o = 1'b0;
    unique case (rd_q)
      mcu_pkg::LR_IDLE: begin
        ld_rdy_o = 1'b1;
        if (ld_vld_i) begin
          cfg_save       = 1'b1;
          baseaddr_set_o = 1'b1;
          rd_d           = mcu_pkg::LR_BUFFED;
        end
      end
      mcu_pkg::LR_BUFFED: begin
        cfg_update_o = 1'b1;
        cntr_rst_o   = 1'b1;
        start_wr     = 1'b1;
        rd_d         = mcu_pkg::LR_WAIT;
      end
      mcu_pkg::LR_WAIT: begin
        if (buffered) begin
          rd_d = mcu_pkg::LR_READ;
        end
      end
      mcu_pkg::LR_READ: begin
        ldbuff_read_stall_o = !vlane_load_rdy_i;
        rvalid              = vlane_load_rdy_i && !ldbuff_read_done_i;
        ldbuff_ren_o        = rvalid;
        if (vlane_load_last_o && vlane_load_rdy_i) begin
          rd_d = mcu_pkg::LR_IDLE;
        end
      end
    endcase
  end

  ////////////////////////////////////////
  // AXI read channel to load buffer
  ////////////////////////////////////////
  always_comb begin
    wr_d              = wr_q;
    rstart_lvl        = 1'b0;
    rd_tready_o       = 1'b0;
    ldbuff_wen_o      = 1'b0;
    baseaddr_update_o = 1'b0;
    buffered          = 1'b0;
    unique case (wr_q)
      mcu_pkg::LW_IDLE: begin
        if (start_wr) begin
          wr_d = (load_cfg_o.mode == mcu_pkg::MODE_STRIDED) ? mcu_pkg::LW_STRIDED
                                                             : mcu_pkg::LW_UNIT;
        end
      end
      mcu_pkg::LW_UNIT: begin
        rstart_lvl   = 1'b1;
        rd_tready_o  = 1'b1;
        ldbuff_wen_o = rd_tvalid_i;
        // Master closing the burst also ends it
        if ((rd_tlast_i && rd_tvalid_i) || ctrl_rdone_i) begin
          wr_d     = mcu_pkg::LW_IDLE;
          buffered = 1'b1;
        end
      end
      mcu_pkg::LW_STRIDED: begin
        rstart_lvl   = 1'b1;
        rd_tready_o  = 1'b1;
        ldbuff_wen_o = rd_tvalid_i;
        if (rd_tlast_i && rd_tvalid_i) begin
          if (ldbuff_write_done_i) begin
            wr_d     = mcu_pkg::LW_IDLE;
            buffered = 1'b1;
          end else begin
            wr_d = mcu_pkg::LW_STRIDED_NEXT;
          end
        end
      end
      mcu_pkg::LW_STRIDED_NEXT: begin
        // Step the address, start level drops for one cycle
        baseaddr_update_o = 1'b1;
        wr_d              = mcu_pkg::LW_STRIDED;
      end
    endcase
  end

  // A captured request must have a legal register group
  assert property (@(posedge clk) disable iff (!rstn) cfg_save |-> emul_valid_i)
    else $error("load request captured with illegal EMUL");

  // Last beat only once the buffer has no more reads to give
  assert property (@(posedge clk) disable iff (!rstn)
                   vlane_load_last_o |-> vlane_load_dvalid_o && ldbuff_read_done_i)
    else $error("lane last beat without valid or before read done");

endmodule

`default_nettype wire

// File: logic/mcu_pkg.sv
////////////////////////////////////////
// Memory control unit shared widths,
// encodings and types
////////////////////////////////////////
`default_nettype none

package mcu_pkg;

  // Width of every SEW, LMUL, width and EMUL code
  localparam int CODE_W = 3;
  // LMUL code with no legal meaning
  localparam logic [CODE_W-1:0] LMUL_RESERVED = 3'd4;
  // Read-valid delay line, beats leave from the second tap
  localparam int DLINE_DEPTH = 3;

  typedef enum logic {
    MODE_UNIT,
    MODE_STRIDED
  } access_mode_e;

  // Request fields from the scheduler
  typedef struct packed {
    logic [CODE_W-1:0] sew;
    logic [CODE_W-1:0] lmul;
    logic [CODE_W-1:0] data_width;
    logic              strided;
  } mcu_req_t;

  // Configuration held for the buffer array
  typedef struct packed {
    access_mode_e      mode;
    logic [CODE_W-1:0] eew;
    logic [CODE_W-1:0] emul;
  } mem_cfg_t;

  typedef enum logic [1:0] {ST_IDLE, ST_BUFFED, ST_WRITE, ST_WAIT} store_fsm_e;

  typedef enum logic [1:0] {SR_IDLE, SR_UNIT, SR_STRIDED, SR_STRIDED_WAIT} store_rd_fsm_e;

  typedef enum logic [1:0] {LR_IDLE, LR_BUFFED, LR_WAIT, LR_READ} load_rd_fsm_e;

  typedef enum logic [1:0] {LW_IDLE, LW_UNIT, LW_STRIDED, LW_STRIDED_NEXT} load_wr_fsm_e;

endpackage

`default_nettype wire

// File: logic/mcu_top.sv
////////////////////////////////////////
// Memory control unit top, shared EMUL
// table with store and load controllers
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module mcu_top (
  input  logic                  clk,
  input  logic                  rstn,
  // Scheduler
  input  mcu_pkg::mcu_req_t     mcu_req_i,
  input  logic                  mcu_st_vld_i,
  output logic                  mcu_st_rdy_o,
  input  logic                  mcu_ld_vld_i,
  output logic                  mcu_ld_rdy_o,
  // Buffer array, stores
  output mcu_pkg::mem_cfg_t     store_cfg_o,
  output logic                  store_cfg_update_o,
  output logic                  store_cntr_rst_o,
  output logic                  store_baseaddr_set_o,
  output logic                  store_baseaddr_update_o,
  output logic                  sbuff_wen_o,
  output logic                  sdbuff_ren_o,
  output logic                  sdbuff_read_stall_o,
  input  logic                  sdbuff_write_done_i,
  input  logic                  sdbuff_read_done_i,
  input  logic                  sdbuff_read_rdy_i,
  // Buffer array, loads
  output mcu_pkg::mem_cfg_t     load_cfg_o,
  output logic                  load_cfg_update_o,
  output logic                  load_cntr_rst_o,
  output logic                  load_baseaddr_set_o,
  output logic                  load_baseaddr_update_o,
  output logic                  ldbuff_wen_o,
  output logic                  ldbuff_ren_o,
  output logic                  ldbuff_read_stall_o,
  output logic                  ldbuff_read_flush_o,
  input  logic                  ldbuff_write_done_i,
  input  logic                  ldbuff_read_done_i,
  // Vector lanes
  input  logic                  vlane_store_dvalid_i,
  output logic                  vlane_store_rdy_o,
  input  logic                  vlane_load_rdy_i,
  output logic                  vlane_load_dvalid_o,
  output logic                  vlane_load_last_o,
  // AXI read channel
  output logic                  ctrl_rstart_o,
  input  logic                  ctrl_rdone_i,
  input  logic                  rd_tvalid_i,
  output logic                  rd_tready_o,
  input  logic                  rd_tlast_i,
  // AXI write channel
  output logic                  ctrl_wstart_o,
  input  logic                  ctrl_wdone_i,
  output logic                  wr_tvalid_o,
  input  logic                  wr_tready_i
);

  logic [mcu_pkg::CODE_W-1:0] emul;
  logic                       emul_valid;

  emul_table u_emul (
    .req_i        (mcu_req_i),
    .emul_o       (emul),
    .emul_valid_o (emul_valid)
  );

  store_ctrl u_store (
    .clk                  (clk),
    .rstn                 (rstn),
    .req_i                (mcu_req_i),
    .st_vld_i             (mcu_st_vld_i),
    .st_rdy_o             (mcu_st_rdy_o),
    .emul_i               (emul),
    .emul_valid_i         (emul_valid),
    .store_cfg_o          (store_cfg_o),
    .cfg_update_o         (store_cfg_update_o),
    .cntr_rst_o           (store_cntr_rst_o),
    .baseaddr_set_o       (store_baseaddr_set_o),
    .baseaddr_update_o    (store_baseaddr_update_o),
    .sbuff_wen_o          (sbuff_wen_o),
    .sdbuff_ren_o         (sdbuff_ren_o),
    .sdbuff_read_stall_o  (sdbuff_read_stall_o),
    .sdbuff_write_done_i  (sdbuff_write_done_i),
    .sdbuff_read_done_i   (sdbuff_read_done_i),
    .sdbuff_read_rdy_i    (sdbuff_read_rdy_i),
    .vlane_store_dvalid_i (vlane_store_dvalid_i),
    .vlane_store_rdy_o    (vlane_store_rdy_o),
    .ctrl_wstart_o        (ctrl_wstart_o),
    .ctrl_wdone_i         (ctrl_wdone_i),
    .wr_tvalid_o          (wr_tvalid_o),
    .wr_tready_i          (wr_tready_i)
  );

  load_ctrl u_load (
    .clk                 (clk),
    .rstn                (rstn),
    .req_i               (mcu_req_i),
    .ld_vld_i            (mcu_ld_vld_i),
    .ld_rdy_o            (mcu_ld_rdy_o),
    .emul_i              (emul),
    .emul_valid_i        (emul_valid),
    .load_cfg_o          (load_cfg_o),
    .cfg_update_o        (load_cfg_update_o),
    .cntr_rst_o          (load_cntr_rst_o),
    .baseaddr_set_o      (load_baseaddr_set_o),
    .baseaddr_update_o   (load_baseaddr_update_o),
    .ldbuff_wen_o        (ldbuff_wen_o),
    .ldbuff_ren_o        (ldbuff_ren_o),
    .ldbuff_read_stall_o (ldbuff_read_stall_o),
    .ldbuff_read_flush_o (ldbuff_read_flush_o),
    .ldbuff_write_done_i (ldbuff_write_done_i),
    .ldbuff_read_done_i  (ldbuff_read_done_i),
    .vlane_load_rdy_i    (vlane_load_rdy_i),
    .vlane_load_dvalid_o (vlane_load_dvalid_o),
    .vlane_load_last_o   (vlane_load_last_o),
    .ctrl_rstart_o       (ctrl_rstart_o),
    .ctrl_rdone_i        (ctrl_rdone_i),
    .rd_tvalid_i         (rd_tvalid_i),
    .rd_tready_o         (rd_tready_o),
    .rd_tlast_i          (rd_tlast_i)
  );

endmodule

`default_nettype wire

// File: logic/store_ctrl.sv
////////////////////////////////////////
// Store controller: lanes into the store
// buffer, buffer onto the AXI write side
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module store_ctrl (
  input  logic                        clk,
  input  logic                        rstn,
  // Scheduler
  input  mcu_pkg::mcu_req_t           req_i,
  input  logic                        st_vld_i,
  output logic                        st_rdy_o,
  // EMUL lookup
  input  logic [mcu_pkg::CODE_W-1:0]  emul_i,
  input  logic                        emul_valid_i,
  // Buffer array
  output mcu_pkg::mem_cfg_t           store_cfg_o,
  output logic                        cfg_update_o,
  output logic                        cntr_rst_o,
  output logic                        baseaddr_set_o,
  output logic                        baseaddr_update_o,
  output logic                        sbuff_wen_o,
  output logic                        sdbuff_ren_o,
  output logic                        sdbuff_read_stall_o,
  input  logic                        sdbuff_write_done_i,
  input  logic                        sdbuff_read_done_i,
  input  logic                        sdbuff_read_rdy_i,
  // Vector lanes
  input  logic                        vlane_store_dvalid_i,
  output logic                        vlane_store_rdy_o,
  // AXI write channel
  output logic                        ctrl_wstart_o,
  input  logic                        ctrl_wdone_i,
  output logic                        wr_tvalid_o,
  input  logic                        wr_tready_i
);

  mcu_pkg::store_fsm_e               wr_q, wr_d;
  mcu_pkg::store_rd_fsm_e            rd_q, rd_d;
  logic                              cfg_save;
  logic                              start_rd;
  logic                              rd_done;
  logic                              rd_fin_q;
  logic                              wstart_lvl;
  logic                              wstart_q;
  logic                              rvalid;
  logic                              beat_ok;
  logic [mcu_pkg::DLINE_DEPTH-1:0]   dline;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_q     <= mcu_pkg::ST_IDLE;
      rd_q     <= mcu_pkg::SR_IDLE;
      wstart_q <= 1'b0;
      rd_fin_q <= 1'b0;
    end else begin
      wr_q     <= wr_d;
      rd_q     <= rd_d;
      wstart_q <= wstart_lvl;
      // Read side may finish before the lanes are done writing
      if (cfg_save) begin
        rd_fin_q <= 1'b0;
      end else if (rd_done) begin
        rd_fin_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      store_cfg_o <= '0;
    end else if (cfg_save) begin
      store_cfg_o.mode <= req_i.strided ? mcu_pkg::MODE_STRIDED : mcu_pkg::MODE_UNIT;
      store_cfg_o.eew  <= req_i.data_width;
      store_cfg_o.emul <= emul_i;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dline <= '0;
    end else if (!sdbuff_read_stall_o) begin
      dline <= {dline[mcu_pkg::DLINE_DEPTH-2:0], rvalid};
    end
  end

  // Beat at the output tap, offered only while a burst is open
  assign beat_ok       = dline[1] && sdbuff_read_rdy_i;
  assign wr_tvalid_o   = beat_ok && wstart_lvl;
  assign ctrl_wstart_o = wstart_lvl && !wstart_q;

  ////////////////////////////////////////
  // Lanes to store buffer
  ////////////////////////////////////////
  always_comb begin
    wr_d              = wr_q;
    st_rdy_o          = 1'b0;
    cfg_save          = 1'b0;
    baseaddr_set_o    = 1'b0;
    cfg_update_o      = 1'b0;
    cntr_rst_o        = 1'b0;
    start_rd          = 1'b0;
    vlane_store_rdy_o = 1'b0;
    sbuff_wen_o       = 1'b0;
    unique case (wr_q)
      mcu_pkg::ST_IDLE: begin
        st_rdy_o = 1'b1;
        if (st_vld_i) begin
          cfg_save       = 1'b1;
          baseaddr_set_o = 1'b1;
          wr_d           = mcu_pkg::ST_BUFFED;
        end
      end
      mcu_pkg::ST_BUFFED: begin
        cfg_update_o = 1'b1;
        cntr_rst_o   = 1'b1;
        start_rd     = 1'b1;
        wr_d         = mcu_pkg::ST_WRITE;
      end
      mcu_pkg::ST_WRITE: begin
        vlane_store_rdy_o = 1'b1;
        sbuff_wen_o       = vlane_store_dvalid_i;
        if (sdbuff_write_done_i && vlane_store_dvalid_i) begin
          wr_d = mcu_pkg::ST_WAIT;
        end
      end
      mcu_pkg::ST_WAIT: begin
        if (rd_done || rd_fin_q) begin
          wr_d = mcu_pkg::ST_IDLE;
        end
      end
    endcase
  end

  ////////////////////////////////////////
  // Store buffer to AXI write channel
  ////////////////////////////////////////
  always_comb begin
    rd_d                = rd_q;
    wstart_lvl          = 1'b0;
    rvalid              = 1'b0;
    sdbuff_ren_o        = 1'b0;
    sdbuff_read_stall_o = 1'b0;
    baseaddr_update_o   = 1'b0;
    rd_done             = 1'b0;
    unique case (rd_q)
      mcu_pkg::SR_IDLE: begin
        if (start_rd) begin
          rd_d = (store_cfg_o.mode == mcu_pkg::MODE_STRIDED) ? mcu_pkg::SR_STRIDED
                                                              : mcu_pkg::SR_UNIT;
        end
      end
      mcu_pkg::SR_UNIT, mcu_pkg::SR_STRIDED: begin
        wstart_lvl          = 1'b1;
        sdbuff_read_stall_o = !sdbuff_read_rdy_i || !wr_tready_i;
        rvalid              = sdbuff_read_rdy_i && wr_tready_i && !sdbuff_read_done_i;
        sdbuff_ren_o        = rvalid;
        if (rd_q == mcu_pkg::SR_UNIT) begin
          if (ctrl_wdone_i) begin
            rd_d    = mcu_pkg::SR_IDLE;
            rd_done = 1'b1;
          end
        end else if (beat_ok && wr_tready_i) begin
          // One beat per strided burst
          rd_d = mcu_pkg::SR_STRIDED_WAIT;
        end
      end
      mcu_pkg::SR_STRIDED_WAIT: begin
        sdbuff_read_stall_o = 1'b1;
        if (ctrl_wdone_i) begin
          baseaddr_update_o = 1'b1;
          if (sdbuff_read_done_i && dline[mcu_pkg::DLINE_DEPTH-2:0] == '0) begin
            rd_d    = mcu_pkg::SR_IDLE;
            rd_done = 1'b1;
          end else begin
            rd_d = mcu_pkg::SR_STRIDED;
          end
        end
      end
    endcase
  end

  // A captured request must have a legal register group
  assert property (@(posedge clk) disable iff (!rstn) cfg_save |-> emul_valid_i)
    else $error("store request captured with illegal EMUL");

  // No buffer read into a frozen delay line
  assert property (@(posedge clk) disable iff (!rstn) sdbuff_ren_o |-> !sdbuff_read_stall_o)
    else $error("store buffer read during stall");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the MCU testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mcu_tb -f list.f -o mcu_sim \
  && ./obj_dir/mcu_sim > sim.log 2>&1 \
  || echo "Build or simulation error"
cat sim.log 2>/dev/null
grep -q "^TESTS PASSED$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/mcu_tb.sv
////////////////////////////////////////
// Memory control unit testbench, table
// driven loads and stores with stubs
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module mcu_tb;

  typedef struct packed {
    logic              is_load;
    mcu_pkg::mcu_req_t req;
    logic [7:0]        beats;
  } row_t;

  // Running event totals, sampled on the rising edge
  typedef enum int {
    C_SWR, C_SRD, C_WHS, C_WSTART, C_SUPD, C_SCFG, C_SCNT, C_SSET,
    C_LWR, C_LRD, C_RHS, C_RSTART, C_LUPD, C_LCFG, C_LCNT, C_LSET, C_LACC, C_LLAST,
    C_NUM
  } cnt_e;

  logic              clk;
  logic              rstn;
  mcu_pkg::mcu_req_t mcu_req_i;
  logic              mcu_st_vld_i;
  logic              mcu_st_rdy_o;
  logic              mcu_ld_vld_i;
  logic              mcu_ld_rdy_o;
  mcu_pkg::mem_cfg_t store_cfg_o;
  logic              store_cfg_update_o;
  logic              store_cntr_rst_o;
  logic              store_baseaddr_set_o;
  logic              store_baseaddr_update_o;
  logic              sbuff_wen_o;
  logic              sdbuff_ren_o;
  logic              sdbuff_read_stall_o;
  logic              sdbuff_write_done_i;
  logic              sdbuff_read_done_i;
  logic              sdbuff_read_rdy_i;
  mcu_pkg::mem_cfg_t load_cfg_o;
  logic              load_cfg_update_o;
  logic              load_cntr_rst_o;
  logic              load_baseaddr_set_o;
  logic              load_baseaddr_update_o;
  logic              ldbuff_wen_o;
  logic              ldbuff_ren_o;
  logic              ldbuff_read_stall_o;
  logic              ldbuff_read_flush_o;
  logic              ldbuff_write_done_i;
  logic              ldbuff_read_done_i;
  logic              vlane_store_dvalid_i;
  logic              vlane_store_rdy_o;
  logic              vlane_load_rdy_i;
  logic              vlane_load_dvalid_o;
  logic              vlane_load_last_o;
  logic              ctrl_rstart_o;
  logic              ctrl_rdone_i;
  logic              rd_tvalid_i;
  logic              rd_tready_o;
  logic              rd_tlast_i;
  logic              ctrl_wstart_o;
  logic              ctrl_wdone_i;
  logic              wr_tvalid_o;
  logic              wr_tready_i;

  row_t  rows[$];
  string row_names[$];
  row_t  cur;
  string name;
  // 0 idle, 1 store row running, 2 load row running
  int    active;
  int    wdone_sent;
  int    tot[C_NUM];
  int    base[C_NUM];
  int    checks;
  int    errors;
  int    cycles;
  int    cycle_limit;

  mcu_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rstn) begin
      tot[C_SWR]    += int'(sbuff_wen_o);
      tot[C_SRD]    += int'(sdbuff_ren_o);
      tot[C_WHS]    += int'(wr_tvalid_o && wr_tready_i);
      tot[C_WSTART] += int'(ctrl_wstart_o);
      tot[C_SUPD]   += int'(store_baseaddr_update_o);
      tot[C_SCFG]   += int'(store_cfg_update_o);
      tot[C_SCNT]   += int'(store_cntr_rst_o);
      tot[C_SSET]   += int'(store_baseaddr_set_o);
      tot[C_LWR]    += int'(ldbuff_wen_o);
      tot[C_LRD]    += int'(ldbuff_ren_o);
      tot[C_RHS]    += int'(rd_tvalid_i && rd_tready_o);
      tot[C_RSTART] += int'(ctrl_rstart_o);
      tot[C_LUPD]   += int'(load_baseaddr_update_o);
      tot[C_LCFG]   += int'(load_cfg_update_o);
      tot[C_LCNT]   += int'(load_cntr_rst_o);
      tot[C_LSET]   += int'(load_baseaddr_set_o);
      tot[C_LACC]   += int'(vlane_load_dvalid_o && vlane_load_rdy_i);
      tot[C_LLAST]  += int'(vlane_load_last_o && vlane_load_rdy_i);
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic int count_since(cnt_e c);
    return tot[c] - base[c];
  endfunction

  // Log2 arithmetic, LMUL codes 5 to 7 stand for -3 to -1
  function automatic logic [mcu_pkg::CODE_W-1:0] expected_emul(mcu_pkg::mcu_req_t r);
    int lm;
    int e;
    lm = (r.lmul < 3'd4) ? int'(r.lmul) : int'(r.lmul) - 8;
    e  = lm + int'(r.data_width) - int'(r.sew);
    if (e < 0) begin
      e = e + 8;
    end
    return e[mcu_pkg::CODE_W-1:0];
  endfunction

  task automatic check_equal(string what, int exp_v, int got_v);
    checks++;
    assert (got_v == exp_v) else begin
      errors++;
      $display("Fail %s %s: expected %0d, got %0d", name, what, exp_v, got_v);
    end
  endtask

  task automatic add_row(string nm, logic ld, logic [2:0] sew, logic [2:0] lmul,
                         logic [2:0] wd, logic st, int n);
    row_t r;
    r.is_load        = ld;
    r.req.sew        = sew;
    r.req.lmul       = lmul;
    r.req.data_width = wd;
    r.req.strided    = st;
    r.beats          = n[7:0];
    rows.push_back(r);
    row_names.push_back(nm);
  endtask

  ////////////////////////////////////////
  // Buffer, lane and AXI stubs
  ////////////////////////////////////////
  task automatic drive_stubs();
    int n;
    n = int'(cur.beats);
    // Store side: lanes always have data, buffer always readable
    vlane_store_dvalid_i = (active == 1);
    sdbuff_write_done_i  = (active == 1) && (count_since(C_SWR) >= n - 1);
    sdbuff_read_done_i   = (active == 1) && (count_since(C_SRD) >= n);
    wr_tready_i          = (active == 1) && ($urandom % 4 != 0);
    ctrl_wdone_i         = 1'b0;
    // Write burst closes after one beat when strided, after all beats otherwise
    if (active == 1 && count_since(C_WHS) > wdone_sent &&
        (cur.req.strided || count_since(C_WHS) == n)) begin
      ctrl_wdone_i = 1'b1;
      wdone_sent   = count_since(C_WHS);
    end
    // Load side
    ldbuff_write_done_i = (active == 2) && (count_since(C_LWR) >= n - 1);
    ldbuff_read_done_i  = (active == 2) && (count_since(C_LRD) >= n);
    vlane_load_rdy_i    = (active == 2) && ($urandom % 4 != 0);
    rd_tvalid_i         = (active == 2) && (count_since(C_RHS) < n) && ($urandom % 3 != 0);
    rd_tlast_i          = rd_tvalid_i && (cur.req.strided || count_since(C_RHS) == n - 1);
  endtask

  task automatic step();
    @(negedge clk);
    drive_stubs();
  endtask

  task automatic check_reset_outputs();
    logic [21:0] ctl;
    name = "reset";
    ctl  = {store_cfg_update_o, store_cntr_rst_o, store_baseaddr_set_o,
            store_baseaddr_update_o, sbuff_wen_o, sdbuff_ren_o, sdbuff_read_stall_o,
            load_cfg_update_o, load_cntr_rst_o, load_baseaddr_set_o,
            load_baseaddr_update_o, ldbuff_wen_o, ldbuff_ren_o, ldbuff_read_stall_o,
            ldbuff_read_flush_o, vlane_store_rdy_o, vlane_load_dvalid_o,
            vlane_load_last_o, ctrl_rstart_o, rd_tready_o, ctrl_wstart_o, wr_tvalid_o};
    check_equal("rdy outputs", 3, int'({mcu_st_rdy_o, mcu_ld_rdy_o}));
    check_equal("control outputs", 0, int'(ctl));
    check_equal("cfg outputs", 0, int'({store_cfg_o, load_cfg_o}));
  endtask

  task automatic run_test(int idx);
    mcu_pkg::mem_cfg_t exp_cfg;
    int                n;
    cur          = rows[idx];
    name         = row_names[idx];
    n            = int'(cur.beats);
    base         = tot;
    wdone_sent   = 0;
    active       = cur.is_load ? 2 : 1;
    mcu_req_i    = cur.req;
    mcu_st_vld_i = !cur.is_load;
    mcu_ld_vld_i = cur.is_load;
    drive_stubs();
    step();
    mcu_st_vld_i = 1'b0;
    mcu_ld_vld_i = 1'b0;
    // Path drains back to idle, watchdog covers a hang
    while (!(cur.is_load ? mcu_ld_rdy_o : mcu_st_rdy_o)) begin
      step();
    end
    active = 0;
    drive_stubs();
    exp_cfg.mode = cur.req.strided ? mcu_pkg::MODE_STRIDED : mcu_pkg::MODE_UNIT;
    exp_cfg.eew  = cur.req.data_width;
    exp_cfg.emul = expected_emul(cur.req);
    if (cur.is_load) begin
      check_equal("load cfg", int'(exp_cfg), int'(load_cfg_o));
      check_equal("load cfg updates", 1, count_since(C_LCFG));
      check_equal("load counter resets", 1, count_since(C_LCNT));
      check_equal("load base sets", 1, count_since(C_LSET));
      check_equal("load buffer writes", n, count_since(C_LWR));
      check_equal("load buffer reads", n, count_since(C_LRD));
      check_equal("read starts", cur.req.strided ? n : 1, count_since(C_RSTART));
      check_equal("load base updates", cur.req.strided ? n - 1 : 0, count_since(C_LUPD));
      check_equal("lane beats", n, count_since(C_LACC));
      check_equal("lane last beats", 1, count_since(C_LLAST));
    end else begin
      check_equal("store cfg", int'(exp_cfg), int'(store_cfg_o));
      check_equal("store cfg updates", 1, count_since(C_SCFG));
      check_equal("store counter resets", 1, count_since(C_SCNT));
      check_equal("store base sets", 1, count_since(C_SSET));
      check_equal("store buffer writes", n, count_since(C_SWR));
      check_equal("store buffer reads", n, count_since(C_SRD));
      check_equal("write handshakes", n, count_since(C_WHS));
      check_equal("write starts", cur.req.strided ? n : 1, count_since(C_WSTART));
      check_equal("store base updates", cur.req.strided ? n : 0, count_since(C_SUPD));
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    int total_beats;
    void'($urandom(32'he89a));
    rstn              = 1'b0;
    mcu_req_i         = '0;
    mcu_st_vld_i      = 1'b0;
    mcu_ld_vld_i      = 1'b0;
    sdbuff_read_rdy_i = 1'b1;
    ctrl_rdone_i      = 1'b0;
    cur               = '0;
    active            = 0;
    drive_stubs();
    // name, load, sew, lmul, width, strided, beats
    add_row("st_unit_m1",        1'b0, 3'd2, 3'd0, 3'd2, 1'b0, 6);
    add_row("st_strided_mf2",    1'b0, 3'd2, 3'd1, 3'd0, 1'b1, 4);
    add_row("st_unit_single",    1'b0, 3'd0, 3'd0, 3'd0, 1'b0, 1);
    add_row("st_unit_m4",        1'b0, 3'd0, 3'd1, 3'd1, 1'b0, 8);
    add_row("st_strided_m1",     1'b0, 3'd1, 3'd7, 3'd2, 1'b1, 5);
    add_row("ld_unit_m8",        1'b1, 3'd1, 3'd2, 3'd2, 1'b0, 7);
    add_row("ld_strided_mf8",    1'b1, 3'd2, 3'd5, 3'd2, 1'b1, 4);
    add_row("ld_unit_mf8",       1'b1, 3'd2, 3'd6, 3'd1, 1'b0, 3);
    add_row("ld_strided_single", 1'b1, 3'd0, 3'd0, 3'd0, 1'b1, 1);
    add_row("ld_strided_m1",     1'b1, 3'd0, 3'd0, 3'd0, 1'b1, 6);
    total_beats = 0;
    foreach (rows[i]) begin
      total_beats += int'(rows[i].beats);
    end
    cycle_limit = 40 * total_beats + 100;
    repeat (2) @(negedge clk);
    rstn = 1'b1;
    step();
    check_reset_outputs();
    foreach (rows[i]) begin
      run_test(i);
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
